//--- design/sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

    // ========================================
    // Command frame
    // ========================================

    // Start, direction, index, argument, CRC7, end
    localparam int cmd_bits = 48;
    // Part of the command covered by the CRC
    localparam int cmd_payload_bits = 40;

    // ========================================
    // Response frames
    // ========================================

    localparam int r48_bits = 48;
    localparam int r136_bits = 136;

    // Start, direction and reserved bits of R136 are outside its CRC
    localparam int r136_crc_skip = 8;

    // Samples ignored once the host lets go of the line
    localparam int turnaround_bits = 2;

    // x^7 + x^3 + 1
    localparam logic [6:0] crc7_poly = 7'h09;

    typedef enum logic [1:0] {
        resp_none = 2'd0,
        resp_r48  = 2'd1,
        resp_r136 = 2'd2
    } resp_type_t;

endpackage

`default_nettype wire

//--- design/sd_port_pkg.sv
`default_nettype none

package sd_port_pkg;

    // One command as handed to the controller
    typedef struct packed {
        logic [sd_proto_pkg::cmd_payload_bits-1:0] payload;
        sd_proto_pkg::resp_type_t resp_type;
    } cmd_req_t;

    // Short response, right aligned in the shared word
    typedef struct packed {
        logic [sd_proto_pkg::r136_bits-sd_proto_pkg::r48_bits-1:0] pad;
        logic start;
        logic dir;
        logic [5:0] index;
        logic [31:0] argument;
        logic [6:0] crc;
        logic end_bit;
    } r48_frame_t;

    // Long response (CID or CSD register)
    typedef struct packed {
        logic start;
        logic dir;
        logic [5:0] reserved;
        logic [sd_proto_pkg::r136_bits-16-1:0] body;
        logic [6:0] crc;
        logic end_bit;
    } r136_frame_t;

    typedef union packed {
        r48_frame_t r48;
        r136_frame_t r136;
    } resp_word_u;

    typedef struct packed {
        logic crc_err;
        logic end_err;
    } resp_status_t;

    // CMD pin drive
    typedef struct packed {
        logic out;
        logic oe;
    } cmd_line_t;

endpackage

`default_nettype wire

//--- design/sd_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_bit_timer #(
    parameter int clk_div = 4
) (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic load_bits,
    input wire logic [7:0] bit_count_load,
    input wire logic count_on_rise,
    output logic sd_clk,
    output logic fall_tick,
    output logic rise_tick,
    output logic bit_zero
);

    localparam int phase_w = $clog2(clk_div);

    logic [phase_w-1:0] phase;
    logic [7:0] bit_count;
    logic count_tick;

    // ========================================
    // SD clock divider
    // ========================================

    // Ticks come out in the same cycle as the new sd_clk level
    always_ff @(posedge clk_fast) begin
        if (reset) begin
            phase <= '0;
            sd_clk <= 1'b0;
            fall_tick <= 1'b0;
            rise_tick <= 1'b0;
        end else begin
            fall_tick <= 1'b0;
            rise_tick <= 1'b0;
            if (phase == phase_w'(clk_div - 1)) begin
                phase <= '0;
                sd_clk <= !sd_clk;
                fall_tick <= sd_clk;
                rise_tick <= !sd_clk;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // ========================================
    // Frame bit counter
    // ========================================

    // Drive edge while sending, sample edge while receiving
    assign count_tick = count_on_rise ? rise_tick : fall_tick;

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            bit_count <= '0;
        end else if (load_bits) begin
            bit_count <= bit_count_load;
        end else if (count_tick && (bit_count != 8'd0)) begin
            bit_count <= bit_count - 8'd1;
        end
    end

    assign bit_zero = (bit_count == 8'd0);

    // High phase of sd_clk lasts exactly clk_div cycles
    a_high_half_period: assert property (
        @(posedge clk_fast) disable iff (reset) rise_tick |-> ##clk_div fall_tick
    );

endmodule

`default_nettype wire

//--- design/sd_crc7.sv
`timescale 1ns/1ps
`default_nettype none

module sd_crc7 (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic clear,
    input wire logic enable,
    input wire logic data_bit,
    output logic [6:0] remainder
);

    logic feedback;

    // Incoming bit against the register MSB
    assign feedback = data_bit ^ remainder[6];

    always_ff @(posedge clk_fast) begin
        if (reset || clear) begin
            remainder <= '0;
        end else if (enable) begin
            remainder <= {remainder[5:0], 1'b0} ^ (feedback ? sd_proto_pkg::crc7_poly : 7'd0);
        end
    end

endmodule

`default_nettype wire

//--- design/sd_cmd_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_shifter (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic load,
    input wire logic [39:0] payload,
    input wire logic tx_shift,
    input wire logic crc_insert,
    input wire logic [6:0] crc_value,
    input wire logic rx_shift,
    input wire logic oe,
    input wire logic cmd_in,
    output logic tx_bit,
    output logic rx_bit,
    output sd_port_pkg::cmd_line_t cmd_line,
    output sd_port_pkg::resp_word_u resp_word
);

    localparam int sr_bits = sd_proto_pkg::r136_bits;
    localparam int pl_bits = sd_proto_pkg::cmd_payload_bits;
    localparam int crc_bits = $bits(crc_value);

    logic [sr_bits-1:0] shift_reg;

    // ========================================
    // Shared command and response register
    // ========================================

    // Zeros fill in behind the command, so a short response leaves the pad clear
    always_ff @(posedge clk_fast) begin
        rx_bit <= cmd_in;
        if (load) begin
            shift_reg <= {payload, {(sr_bits - pl_bits){1'b0}}};
        end else if (crc_insert) begin
            // CRC lands right behind the payload, end bit after it
            shift_reg[sr_bits-1 -: crc_bits+1] <= {crc_value, 1'b1};
        end else if (tx_shift) begin
            shift_reg <= {shift_reg[sr_bits-2:0], 1'b0};
        end else if (rx_shift) begin
            shift_reg <= {shift_reg[sr_bits-2:0], rx_bit};
        end
    end

    assign tx_bit = shift_reg[sr_bits-1];
    assign resp_word = shift_reg;

    // ========================================
    // CMD line drive
    // ========================================

    // Enable goes up with the first driven bit, line idles high when released
    always_ff @(posedge clk_fast) begin
        if (reset) begin
            cmd_line.out <= 1'b1;
            cmd_line.oe <= 1'b0;
        end else begin
            if (tx_shift) begin
                cmd_line.out <= shift_reg[sr_bits-1];
            end else if (!oe) begin
                cmd_line.out <= 1'b1;
            end
            cmd_line.oe <= oe && (cmd_line.oe || tx_shift);
        end
    end

    a_load_not_with_shift: assert property (
        @(posedge clk_fast) disable iff (reset) load |-> !(tx_shift || rx_shift)
    );

endmodule

`default_nettype wire

//--- design/sd_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_fsm (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic cmd_start,
    input wire sd_port_pkg::cmd_req_t cmd_req,
    input wire logic fall_tick,
    input wire logic rise_tick,
    input wire logic bit_zero,
    input wire logic rx_bit,
    input wire logic [6:0] crc_rx_value,
    input wire logic [6:0] resp_crc_field,
    output logic load_bits,
    output logic [7:0] bit_count_load,
    output logic count_on_rise,
    output logic load,
    output logic tx_shift,
    output logic rx_shift,
    output logic crc_insert,
    output logic oe,
    output logic crc_tx_clear,
    output logic crc_tx_enable,
    output logic crc_rx_clear,
    output logic crc_rx_enable,
    output logic busy,
    output logic cmd_done,
    output logic resp_done,
    output sd_port_pkg::resp_status_t resp_status
);

    localparam int crc_len = $bits(sd_proto_pkg::crc7_poly);
    localparam int skip_w = $clog2(sd_proto_pkg::r136_crc_skip);

    // Counts load as bits minus one, the last bit is seen at zero
    localparam logic [7:0] payload_count = 8'(sd_proto_pkg::cmd_payload_bits - 1);
    localparam logic [7:0] crc_count =
        8'(sd_proto_pkg::cmd_bits - sd_proto_pkg::cmd_payload_bits - 2);
    localparam logic [7:0] turn_count = 8'(sd_proto_pkg::turnaround_bits - 1);
    // Head of a response, after the start bit and before the CRC
    localparam logic [7:0] r48_head = 8'(sd_proto_pkg::r48_bits - crc_len - 3);
    localparam logic [7:0] r136_head = 8'(sd_proto_pkg::r136_bits - crc_len - 3);
    // CRC field plus end bit
    localparam logic [7:0] tail_count = 8'(crc_len);

    typedef enum logic [2:0] {
        idle,
        send_payload,
        send_crc,
        send_end,
        turnaround,
        wait_start,
        receive,
        check
    } state_t;

    state_t state;
    state_t state_next;
    logic crc_pending;
    logic [skip_w-1:0] skip_count;
    logic start_bit;
    logic send_done;
    logic recv_done;
    logic is_r136;

    assign is_r136 = (cmd_req.resp_type == sd_proto_pkg::resp_r136);
    assign start_bit = (state == wait_start) && rise_tick && !rx_bit;

    // ========================================
    // Next state and strobes
    // ========================================

    always_comb begin
        state_next = state;
        load_bits = 1'b0;
        bit_count_load = 8'd0;
        tx_shift = 1'b0;
        rx_shift = 1'b0;
        crc_tx_enable = 1'b0;
        crc_rx_enable = 1'b0;
        crc_rx_clear = 1'b0;
        send_done = 1'b0;
        recv_done = 1'b0;
        case (state)
            idle: begin
                if (cmd_start) begin
                    state_next = send_payload;
                    load_bits = 1'b1;
                    bit_count_load = payload_count;
                end
            end
            send_payload: begin
                if (fall_tick) begin
                    tx_shift = 1'b1;
                    crc_tx_enable = 1'b1;
                    if (bit_zero) begin
                        state_next = send_crc;
                        load_bits = 1'b1;
                        bit_count_load = crc_count;
                    end
                end
            end
            send_crc: begin
                if (fall_tick) begin
                    tx_shift = 1'b1;
                    if (bit_zero) begin
                        state_next = send_end;
                        load_bits = 1'b1;
                        bit_count_load = 8'd1;
                    end
                end
            end
            send_end: begin
                // First edge drives the end bit, second one releases the line
                if (fall_tick && !bit_zero) begin
                    tx_shift = 1'b1;
                end else if (fall_tick) begin
                    send_done = 1'b1;
                    if (cmd_req.resp_type == sd_proto_pkg::resp_none) begin
                        state_next = idle;
                    end else begin
                        state_next = turnaround;
                        load_bits = 1'b1;
                        bit_count_load = turn_count;
                    end
                end
            end
            turnaround: begin
                if (rise_tick && bit_zero) begin
                    state_next = wait_start;
                end
            end
            wait_start: begin
                if (start_bit) begin
                    rx_shift = 1'b1;
                    crc_rx_enable = !is_r136;
                    state_next = receive;
                    load_bits = 1'b1;
                    bit_count_load = is_r136 ? r136_head : r48_head;
                end else begin
                    crc_rx_clear = 1'b1;
                end
            end
            receive: begin
                if (rise_tick) begin
                    rx_shift = 1'b1;
                    crc_rx_enable = (skip_count == '0);
                    if (bit_zero) begin
                        state_next = check;
                        load_bits = 1'b1;
                        bit_count_load = tail_count;
                    end
                end
            end
            check: begin
                if (rise_tick) begin
                    rx_shift = 1'b1;
                    if (bit_zero) begin
                        recv_done = 1'b1;
                        state_next = idle;
                    end
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    assign load = (state == idle) && cmd_start;
    assign crc_tx_clear = load;
    // One cycle after the last payload bit, when crc_tx has settled
    assign crc_insert = (state == send_crc) && crc_pending;
    assign oe = (state == send_payload) || (state == send_crc)
        || ((state == send_end) && !send_done);
    assign count_on_rise = (state == turnaround) || (state == wait_start)
        || (state == receive) || (state == check);

    // ========================================
    // State and status registers
    // ========================================

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= idle;
            busy <= 1'b0;
            cmd_done <= 1'b0;
            resp_done <= 1'b0;
            crc_pending <= 1'b0;
            skip_count <= '0;
            resp_status <= '0;
        end else begin
            state <= state_next;
            busy <= (state_next != idle);
            cmd_done <= send_done;
            resp_done <= recv_done;
            crc_pending <= (state != send_crc) && (state_next == send_crc);

            // R136 leaves its first bits out of the CRC
            if (start_bit) begin
                skip_count <= is_r136 ? skip_w'(sd_proto_pkg::r136_crc_skip - 1) : '0;
            end else if (rx_shift && (skip_count != '0)) begin
                skip_count <= skip_count - 1'b1;
            end

            // End bit is still on rx_bit, the CRC field just below it
            if (recv_done) begin
                resp_status.crc_err <= (crc_rx_value != resp_crc_field);
                resp_status.end_err <= !rx_bit;
            end
        end
    end

    // CRC overlay has to fall between two drive edges
    a_crc_insert_between_shifts: assert property (
        @(posedge clk_fast) disable iff (reset) crc_insert |-> !tx_shift
    );

endmodule

`default_nettype wire

//--- design/sd_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_top #(
    parameter int clk_div = 4
) (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic cmd_start,
    input wire sd_port_pkg::cmd_req_t cmd_req,
    input wire logic cmd_in,
    output logic sd_clk,
    output sd_port_pkg::cmd_line_t cmd_line,
    output logic busy,
    output logic cmd_done,
    output logic resp_done,
    output sd_port_pkg::resp_word_u resp_word,
    output sd_port_pkg::resp_status_t resp_status
);

    logic fall_tick;
    logic rise_tick;
    logic bit_zero;
    logic load_bits;
    logic [7:0] bit_count_load;
    logic count_on_rise;
    logic load;
    logic tx_shift;
    logic rx_shift;
    logic crc_insert;
    logic oe;
    logic tx_bit;
    logic rx_bit;
    logic crc_tx_clear;
    logic crc_tx_enable;
    logic crc_rx_clear;
    logic crc_rx_enable;
    logic [6:0] crc_tx_value;
    logic [6:0] crc_rx_value;

    sd_bit_timer #(
        .clk_div(clk_div)
    ) timer (
        .clk_fast(clk_fast),
        .reset(reset),
        .load_bits(load_bits),
        .bit_count_load(bit_count_load),
        .count_on_rise(count_on_rise),
        .sd_clk(sd_clk),
        .fall_tick(fall_tick),
        .rise_tick(rise_tick),
        .bit_zero(bit_zero)
    );

    // CRC field is checked before the end bit shifts in, so it sits at the bottom
    sd_cmd_fsm fsm (
        .clk_fast(clk_fast),
        .reset(reset),
        .cmd_start(cmd_start),
        .cmd_req(cmd_req),
        .fall_tick(fall_tick),
        .rise_tick(rise_tick),
        .bit_zero(bit_zero),
        .rx_bit(rx_bit),
        .crc_rx_value(crc_rx_value),
        .resp_crc_field(resp_word[6:0]),
        .load_bits(load_bits),
        .bit_count_load(bit_count_load),
        .count_on_rise(count_on_rise),
        .load(load),
        .tx_shift(tx_shift),
        .rx_shift(rx_shift),
        .crc_insert(crc_insert),
        .oe(oe),
        .crc_tx_clear(crc_tx_clear),
        .crc_tx_enable(crc_tx_enable),
        .crc_rx_clear(crc_rx_clear),
        .crc_rx_enable(crc_rx_enable),
        .busy(busy),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp_status(resp_status)
    );

    sd_cmd_shifter shifter (
        .clk_fast(clk_fast),
        .reset(reset),
        .load(load),
        .payload(cmd_req.payload),
        .tx_shift(tx_shift),
        .crc_insert(crc_insert),
        .crc_value(crc_tx_value),
        .rx_shift(rx_shift),
        .oe(oe),
        .cmd_in(cmd_in),
        .tx_bit(tx_bit),
        .rx_bit(rx_bit),
        .cmd_line(cmd_line),
        .resp_word(resp_word)
    );

    // Outgoing command CRC
    sd_crc7 crc_tx (
        .clk_fast(clk_fast),
        .reset(reset),
        .clear(crc_tx_clear),
        .enable(crc_tx_enable),
        .data_bit(tx_bit),
        .remainder(crc_tx_value)
    );

    // Incoming response CRC
    sd_crc7 crc_rx (
        .clk_fast(clk_fast),
        .reset(reset),
        .clear(crc_rx_clear),
        .enable(crc_rx_enable),
        .data_bit(rx_bit),
        .remainder(crc_rx_value)
    );

endmodule

`default_nettype wire

//--- tests/sd_cmd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_checker #(
    parameter int clk_div = 4
) (
    input wire logic clk_fast,
    input wire logic reset,
    input wire logic sd_clk,
    input wire sd_port_pkg::cmd_line_t cmd_line,
    input wire logic busy,
    input wire logic cmd_done,
    input wire logic resp_done,
    input wire sd_port_pkg::resp_word_u resp_word,
    input wire sd_port_pkg::resp_status_t resp_status,
    input wire logic test_end,
    input wire logic [95:0] test_name,
    input wire logic [47:0] exp_cmd,
    input wire logic exp_has_resp,
    input wire logic [135:0] exp_resp,
    input wire sd_port_pkg::resp_status_t exp_status,
    output int error_count,
    output int tests_run,
    output int tests_failed
);

    logic sd_prev;
    logic reset_prev;
    logic seen_edge;
    logic resp_seen;
    logic cmd_seen;
    logic [47:0] cap;
    int cap_count;
    int half_cnt;
    int test_errors;

    task automatic report_value(input string what, input logic [135:0] expected,
                                input logic [135:0] actual);
        $display("error %0s %0s expected %h actual %h", test_name, what, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("%0s: %0s", test_name, msg);
        error_count++;
        test_errors++;
    endtask

    initial begin
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        sd_prev = 1'b0;
        reset_prev = 1'b1;
        seen_edge = 1'b0;
        resp_seen = 1'b0;
        cmd_seen = 1'b0;
        cap = '0;
        cap_count = 0;
        half_cnt = 0;
    end

    // Everything sampled mid-cycle, away from the DUT clock edge
    always @(negedge clk_fast) begin
        if (reset) begin
            half_cnt = 0;
            seen_edge = 1'b0;
            cap_count = 0;
        end else begin
            if (reset_prev && (cmd_line.oe || busy || cmd_done || resp_done || !cmd_line.out)) begin
                report_text("outputs not idle right after reset");
            end

            // ========================================
            // SD clock period
            // ========================================
            half_cnt++;
            if (sd_clk != sd_prev) begin
                if (seen_edge && half_cnt != clk_div) begin
                    report_value("sd_clk half period", 136'(clk_div), 136'(half_cnt));
                end
                seen_edge = 1'b1;
                half_cnt = 0;
            end

            // Host bits are stable at the card's sample edge
            if (sd_clk && !sd_prev && cmd_line.oe) begin
                cap = {cap[46:0], cmd_line.out};
                cap_count++;
            end

            // ========================================
            // Frame and response compares
            // ========================================
            if (cmd_done) begin
                cmd_seen = 1'b1;
                if (cap_count != 48) begin
                    report_text($sformatf("CMD driven for %0d sd_clk periods, not 48",
                                          cap_count));
                end
                if (cap != exp_cmd) begin
                    report_value("command frame", 136'(exp_cmd), 136'(cap));
                end
                // Stays busy only while a response is still to come
                if (busy != exp_has_resp) begin
                    report_value("busy with cmd_done", 136'(exp_has_resp), 136'(busy));
                end
                cap_count = 0;
            end

            if (resp_done) begin
                if (!exp_has_resp) begin
                    report_text("resp_done pulsed for a command without a response");
                end else begin
                    resp_seen = 1'b1;
                    if (resp_word != exp_resp) begin
                        report_value("resp_word", exp_resp, resp_word);
                    end
                    if (resp_status != exp_status) begin
                        report_value("resp_status", 136'(exp_status), 136'(resp_status));
                    end
                    if (busy) begin
                        report_text("busy still high when resp_done pulsed");
                    end
                end
            end

            if (test_end) begin
                if (!cmd_seen) begin
                    report_text("cmd_done never pulsed");
                end
                if (exp_has_resp && !resp_seen) begin
                    report_text("resp_done never pulsed");
                end
                tests_run++;
                if (test_errors == 0) begin
                    $display("test %0s passed", test_name);
                end else begin
                    $display("test %0s failed with %0d errors", test_name, test_errors);
                    tests_failed++;
                end
                test_errors = 0;
                resp_seen = 1'b0;
                cmd_seen = 1'b0;
            end
        end
        sd_prev = sd_clk;
        reset_prev = reset;
    end

endmodule

`default_nettype wire

//--- tests/tb_sd_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_cmd_top;

    localparam int clk_div = 4;
    localparam int num_entries = 7;
    localparam int timeout_limit = num_entries * 240 * 2 * clk_div + 200;

    localparam logic [1:0] fault_none = 2'd0;
    localparam logic [1:0] fault_crc = 2'd1;
    localparam logic [1:0] fault_end = 2'd2;

    typedef struct packed {
        logic [95:0] name;
        logic [5:0] index;
        logic [31:0] argument;
        logic use_rand;
        sd_proto_pkg::resp_type_t resp_type;
        logic [1:0] fault;
    } entry_t;

    logic clk_fast;
    logic reset;
    logic cmd_start;
    sd_port_pkg::cmd_req_t cmd_req;
    logic cmd_in;
    logic sd_clk;
    sd_port_pkg::cmd_line_t cmd_line;
    logic busy;
    logic cmd_done;
    logic resp_done;
    sd_port_pkg::resp_word_u resp_word;
    sd_port_pkg::resp_status_t resp_status;

    logic test_end;
    logic [95:0] test_name;
    logic [47:0] exp_cmd;
    logic exp_has_resp;
    logic [135:0] exp_resp;
    sd_port_pkg::resp_status_t exp_status;
    int error_count;
    int tests_run;
    int tests_failed;

    entry_t entries [num_entries];
    logic [31:0] rng;
    logic [135:0] card_frame;
    int card_len;
    int cycle_count;

    sd_cmd_top #(
        .clk_div(clk_div)
    ) UUT (
        .clk_fast(clk_fast),
        .reset(reset),
        .cmd_start(cmd_start),
        .cmd_req(cmd_req),
        .cmd_in(cmd_in),
        .sd_clk(sd_clk),
        .cmd_line(cmd_line),
        .busy(busy),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp_word(resp_word),
        .resp_status(resp_status)
    );

    sd_cmd_checker #(
        .clk_div(clk_div)
    ) scoreboard (
        .clk_fast(clk_fast),
        .reset(reset),
        .sd_clk(sd_clk),
        .cmd_line(cmd_line),
        .busy(busy),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp_word(resp_word),
        .resp_status(resp_status),
        .test_end(test_end),
        .test_name(test_name),
        .exp_cmd(exp_cmd),
        .exp_has_resp(exp_has_resp),
        .exp_resp(exp_resp),
        .exp_status(exp_status),
        .error_count(error_count),
        .tests_run(tests_run),
        .tests_failed(tests_failed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Serial CRC7, x^7 + x^3 + 1, MSB first over the low nbits of data
    function automatic logic [6:0] crc7_of(input logic [135:0] data, input int nbits);
        logic [6:0] c;
        logic fb;
        c = 7'd0;
        for (int i = nbits - 1; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    initial begin
        clk_fast = 1'b0;
        forever #2 clk_fast = ~clk_fast;
    end

    always @(posedge clk_fast) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run went past %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ========================================
    // Stimulus table
    // ========================================
    initial begin
        entries[0] = '{"cmd0_go_idle", 6'd0, 32'h0, 1'b0, sd_proto_pkg::resp_none, fault_none};
        entries[1] = '{"cmd8_if_cond", 6'd8, 32'h1aa, 1'b0, sd_proto_pkg::resp_r48, fault_none};
        entries[2] = '{"cmd55_random", 6'd55, 32'h0, 1'b1, sd_proto_pkg::resp_r48, fault_none};
        entries[3] = '{"cmd2_all_cid", 6'd2, 32'h0, 1'b0, sd_proto_pkg::resp_r136, fault_none};
        entries[4] = '{"cmd17_badcrc", 6'd17, 32'h0, 1'b1, sd_proto_pkg::resp_r48, fault_crc};
        entries[5] = '{"cmd9_bad_end", 6'd9, 32'h0, 1'b1, sd_proto_pkg::resp_r136, fault_end};
        entries[6] = '{"cmd13_status", 6'd13, 32'h0, 1'b1, sd_proto_pkg::resp_none, fault_none};
    end

    initial begin
        logic [39:0] payload;
        logic [31:0] arg;
        logic [39:0] head;
        logic [119:0] body;
        logic [6:0] crc;
        logic end_bit;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;

        cycle_count = 0;
        rng = 32'd50981;
        reset = 1'b1;
        cmd_start = 1'b0;
        cmd_req = '0;
        cmd_in = 1'b1;
        test_end = 1'b0;
        test_name = '0;
        exp_cmd = '0;
        exp_has_resp = 1'b0;
        exp_resp = '0;
        exp_status = '0;
        repeat (8) @(posedge clk_fast);
        #1 reset = 1'b0;
        repeat (20) @(posedge clk_fast);

        for (int n = 0; n < num_entries; n++) begin
            rng = xorshift(rng);
            arg = entries[n].use_rand ? rng : entries[n].argument;
            payload = {1'b0, 1'b1, entries[n].index, arg};

            // Card answer, built from the response frame rules
            r1 = xorshift(rng);
            r2 = xorshift(r1);
            r3 = xorshift(r2);
            rng = r3;
            if (entries[n].resp_type == sd_proto_pkg::resp_r136) begin
                body = {r1, r2, r3, rng[31:8]};
                crc = crc7_of(136'(body), 120);
                card_len = 136;
            end else begin
                head = {1'b0, 1'b0, entries[n].index, r1};
                crc = crc7_of(136'(head), 40);
                card_len = 48;
            end
            end_bit = (entries[n].fault != fault_end);
            if (entries[n].fault == fault_crc) begin
                crc = crc ^ 7'h04;
            end
            if (card_len == 136) begin
                card_frame = {1'b0, 1'b0, 6'h3f, body, crc, end_bit};
            end else begin
                card_frame = {88'd0, head, crc, end_bit};
            end

            @(posedge clk_fast);
            #1;
            test_name = entries[n].name;
            exp_cmd = {payload, crc7_of(136'(payload), 40), 1'b1};
            exp_has_resp = (entries[n].resp_type != sd_proto_pkg::resp_none);
            exp_resp = card_frame;
            exp_status.crc_err = (entries[n].fault == fault_crc);
            exp_status.end_err = (entries[n].fault == fault_end);
            cmd_req.payload = payload;
            cmd_req.resp_type = entries[n].resp_type;
            cmd_start = 1'b1;
            @(posedge clk_fast);
            #1 cmd_start = 1'b0;

            do @(negedge clk_fast); while (!cmd_done);
            if (exp_has_resp) begin
                // Card idles 3 periods after the end bit, then drives on falling sd_clk
                repeat (2) @(negedge sd_clk);
                for (int i = card_len - 1; i >= 0; i--) begin
                    @(negedge sd_clk);
                    #1 cmd_in = card_frame[i];
                end
                @(negedge sd_clk);
                #1 cmd_in = 1'b1;
                while (busy) @(negedge clk_fast);
            end else begin
                repeat (20) @(negedge sd_clk);
            end

            @(posedge clk_fast);
            #1 test_end = 1'b1;
            @(posedge clk_fast);
            #1 test_end = 1'b0;
        end

        repeat (4) @(posedge clk_fast);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_run == num_entries) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/sd_proto_pkg.sv
design/sd_port_pkg.sv
design/sd_bit_timer.sv
design/sd_crc7.sv
design/sd_cmd_shifter.sv
design/sd_cmd_fsm.sv
design/sd_cmd_top.sv
tests/sd_cmd_checker.sv
tests/tb_sd_cmd_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sd_cmd_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
